// File: hw/fetch_mem_subsystem.sv
/*
 * Top of the fetch memory subsystem: one instruction cache per thread, the
 * shared miss arbiter and the response router, with one tagged memory port.
 */

`timescale 1ns/1ps

module fetch_mem_subsystem
    import mem_pkg::*;
    import icache_pkg::*;
(
    input  logic        clock,
    input  logic        reset,

    // Fetch threads
    input  fetch_addr_t fetch_addrs [N_PORTS],
    output fetch_rsp_t  fetch_rsps  [N_PORTS],

    // Memory port
    output mem_req_t    mem_req,
    input  mem_tag_t    transaction_tag,
    input  mem_rsp_t    mem_rsp
);

    ////////////////////////////////////////
    // Internal wiring
    ////////////////////////////////////////

    mem_req_t port_reqs [N_PORTS];
    mem_tag_t port_tags [N_PORTS];
    mem_rsp_t port_rsps [N_PORTS];
    port_id_t grant_port;
    logic     grant_valid;
    logic     credit_return;

    mem_response_router router0 (
        .clock           (clock),
        .reset           (reset),
        .transaction_tag (transaction_tag),
        .mem_rsp         (mem_rsp),
        .grant_port      (grant_port),
        .grant_valid     (grant_valid),
        .port_tags       (port_tags),
        .port_rsps       (port_rsps),
        .credit_return   (credit_return)
    );

    // One cache per thread
    for (genvar p = 0; p < N_PORTS; p++) begin : g_port
        icache icache0 (
            .clock           (clock),
            .reset           (reset),
            .fetch_addr      (fetch_addrs[p]),
            .fetch_rsp       (fetch_rsps[p]),
            .mem_req         (port_reqs[p]),
            .transaction_tag (port_tags[p]),
            .mem_rsp         (port_rsps[p])
        );
    end

    mem_request_arbiter arbiter0 (
        .clock         (clock),
        .reset         (reset),
        .port_reqs     (port_reqs),
        .credit_return (credit_return),
        .mem_req       (mem_req),
        .grant_port    (grant_port),
        .grant_valid   (grant_valid)
    );

endmodule

// File: hw/icache.sv
/*
 * Blocking direct-mapped instruction cache for one fetch thread.
 * Hits answer in the same cycle, misses request the 64-bit block through the
 * shared arbiter and fill when the data with the awaited memory tag returns.
 */

`timescale 1ns/1ps

module icache
    import mem_pkg::*;
    import icache_pkg::*;
(
    input  logic        clock,
    input  logic        reset,

    // Fetch thread
    input  fetch_addr_t fetch_addr,
    output fetch_rsp_t  fetch_rsp,

    // Toward the arbiter
    output mem_req_t    mem_req,

    // From the router, zero unless this cache owns the tag
    input  mem_tag_t    transaction_tag,
    input  mem_rsp_t    mem_rsp
);

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    // Line state, cleared on reset
    icache_line_t lines [ICACHE_LINES];

    // Block data, only read once its line is valid
    mem_block_u blocks [ICACHE_LINES];

    icache_line_t cur_line;
    mem_block_u   cur_block;
    logic         hit;

    ////////////////////////////////////////
    // Miss tracking state
    ////////////////////////////////////////

    // Block address seen last cycle
    cache_tag_t  last_tag;
    line_index_t last_index;

    // Low for the first cycle out of reset so the first address counts as new
    logic        addr_seen;

    // Memory tag of the outstanding fill, zero when none
    mem_tag_t    wait_tag;

    // Miss still waiting for a memory tag
    logic        miss_outstanding;

    logic        changed_addr;
    logic        got_mem_data;
    logic        update_wait_tag;
    logic        unanswered_miss;

    ////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////

    assign cur_line  = lines[fetch_addr.index];
    assign cur_block = blocks[fetch_addr.index];

    assign hit = cur_line.valid && (cur_line.tag == fetch_addr.tag);

    // Combinational from the address
    assign fetch_rsp.valid = hit;
    assign fetch_rsp.insn  = cur_block.insn[fetch_addr.insn_sel];

    ////////////////////////////////////////
    // Miss control
    ////////////////////////////////////////

    // Only the block address matters, insn_sel stays within the block
    assign changed_addr = !addr_seen
                       || (fetch_addr.tag != last_tag)
                       || (fetch_addr.index != last_index);

    // Data for an abandoned block is dropped
    assign got_mem_data = !changed_addr
                       && (wait_tag != '0)
                       && (mem_rsp.tag == wait_tag);

    // New address clears the tag, a pending miss picks up its grant,
    // a fill clears it again since no tag arrives then
    assign update_wait_tag = changed_addr || miss_outstanding || got_mem_data;

    // New miss on a changed address, else keep asking until a tag comes back
    assign unanswered_miss = changed_addr ? !hit
                                          : miss_outstanding && (transaction_tag == '0);

    always_comb begin
        // Block-aligned address of the current fetch
        mem_req.addr = {fetch_addr.tag, fetch_addr.index, 3'b000};
        if (miss_outstanding && !changed_addr) begin
            mem_req.command = mem_load;
        end else begin
            mem_req.command = mem_none;
        end
    end

    ////////////////////////////////////////
    // Registers
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            last_tag         <= '0;
            last_index       <= '0;
            addr_seen        <= 1'b0;
            wait_tag         <= '0;
            miss_outstanding <= 1'b0;
            for (int i = 0; i < ICACHE_LINES; i++) begin
                lines[i] <= '0;
            end
        end else begin
            last_tag         <= fetch_addr.tag;
            last_index       <= fetch_addr.index;
            addr_seen        <= 1'b1;
            miss_outstanding <= unanswered_miss;
            if (update_wait_tag) begin
                wait_tag <= transaction_tag;
            end
            // Line turns valid the cycle after the fill
            if (got_mem_data) begin
                lines[fetch_addr.index].valid <= 1'b1;
                lines[fetch_addr.index].tag   <= fetch_addr.tag;
            end
        end
    end

    // Block data written as one word
    always_ff @(posedge clock) begin
        if (got_mem_data) begin
            blocks[fetch_addr.index].word <= mem_rsp.data.word;
        end
    end

endmodule

// File: hw/icache_pkg.sv
/*
 * Fetch side of the subsystem: thread count, cache geometry, the fetch
 * address split and the per-line state. Import with icache_pkg::*.
 */

package icache_pkg;

    ////////////////////////////////////////
    // Threads and geometry
    ////////////////////////////////////////

    // One cache per hardware thread
    localparam int N_PORTS = 4;
    typedef logic [$clog2(N_PORTS)-1:0] port_id_t;

    localparam int ICACHE_LINES = 16;
    localparam int INDEX_BITS = $clog2(ICACHE_LINES);

    // Fetch addresses are memory byte addresses
    localparam int ADDR_BITS = mem_pkg::MEM_ADDR_BITS;

    // 2 byte offset bits and 1 instruction select bit below the index
    localparam int CTAG_BITS = ADDR_BITS - INDEX_BITS - 3;

    typedef logic [CTAG_BITS-1:0] cache_tag_t;
    typedef logic [INDEX_BITS-1:0] line_index_t;

    ////////////////////////////////////////
    // Fetch interface and line state
    ////////////////////////////////////////

    // Byte address split, MSB first
    typedef struct packed {
        cache_tag_t  tag;
        line_index_t index;
        logic        insn_sel;    // address bit 2
        logic [1:0]  byte_offset;
    } fetch_addr_t;

    typedef struct packed {
        logic       valid;
        cache_tag_t tag;
    } icache_line_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] insn;
    } fetch_rsp_t;

endpackage

// File: hw/mem_pkg.sv
/*
 * Memory side of the fetch subsystem: tags, credits, commands and the block
 * format shared by the caches, the arbiter, the router and the memory model.
 * Import with mem_pkg::* in the module header.
 */

package mem_pkg;

    ////////////////////////////////////////
    // Transaction tags and credits
    ////////////////////////////////////////

    // Live transactions memory can track, tag zero is reserved
    localparam int MEM_TAGS = 15;
    localparam int MEM_TAG_BITS = $clog2(MEM_TAGS + 1);

    // Byte address width on the memory bus
    localparam int MEM_ADDR_BITS = 16;

    // Zero means no tag, nonzero names a live transaction
    typedef logic [MEM_TAG_BITS-1:0] mem_tag_t;

    // Holds 0 to MEM_TAGS credits
    typedef logic [$clog2(MEM_TAGS + 1)-1:0] mem_credit_t;

    typedef logic [MEM_ADDR_BITS-1:0] mem_addr_t;

    typedef enum logic {
        mem_none,
        mem_load
    } mem_command_e;

    ////////////////////////////////////////
    // Block and bus payloads
    ////////////////////////////////////////

    // One 64-bit block, filled as a word and read back as two instructions
    typedef union packed {
        logic [63:0]      word;
        logic [1:0][31:0] insn; // insn[0] is the low half
    } mem_block_u;

    // Request toward memory, address is 8-byte aligned
    typedef struct packed {
        mem_command_e command;
        mem_addr_t    addr;
    } mem_req_t;

    // Data return, a nonzero tag marks valid data
    typedef struct packed {
        mem_tag_t   tag;
        mem_block_u data;
    } mem_rsp_t;

endpackage

// File: hw/mem_request_arbiter.sv
/*
 * Round-robin arbiter for the cache miss requests, one load per cycle.
 * Loads go to memory only while credits remain, and each data return from
 * the router gives one credit back.
 */

`timescale 1ns/1ps

module mem_request_arbiter
    import mem_pkg::*;
    import icache_pkg::*;
(
    input  logic     clock,
    input  logic     reset,

    // Miss requests, one per cache
    input  mem_req_t port_reqs [N_PORTS],

    // Pulse from the router per data response
    input  logic     credit_return,

    // Toward memory and the router
    output mem_req_t mem_req,
    output port_id_t grant_port,
    output logic     grant_valid
);

    ////////////////////////////////////////
    // Round-robin choice
    ////////////////////////////////////////

    // Highest priority port this cycle
    port_id_t    rr_ptr;

    // Free memory transactions
    mem_credit_t credits;

    logic        found;

    always_comb begin
        port_id_t idx;
        found      = 1'b0;
        grant_port = rr_ptr;
        // Scan from the pointer, first requester wins
        for (int k = 0; k < N_PORTS; k++) begin
            idx = port_id_t'((int'(rr_ptr) + k) % N_PORTS);
            if (!found && (port_reqs[idx].command == mem_load)) begin
                found      = 1'b1;
                grant_port = idx;
            end
        end
    end

    // Nothing leaves at zero credits
    assign grant_valid = found && (credits != '0);

    always_comb begin
        if (grant_valid) begin
            mem_req = port_reqs[grant_port];
        end else begin
            mem_req.command = mem_none;
            mem_req.addr    = '0;
        end
    end

    ////////////////////////////////////////
    // Pointer and credit counter
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            rr_ptr  <= '0;
            credits <= mem_credit_t'(MEM_TAGS);
        end else begin
            // Move past the winner
            if (grant_valid) begin
                rr_ptr <= port_id_t'((int'(grant_port) + 1) % N_PORTS);
            end
            // Spend and return may coincide
            case ({grant_valid, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

// File: hw/mem_response_router.sv
/*
 * Routes memory tags and data returns to the cache that owns them.
 * The owner table is written when memory hands out a tag and freed when the
 * data comes back, which also returns one credit to the arbiter.
 */

`timescale 1ns/1ps

module mem_response_router
    import mem_pkg::*;
    import icache_pkg::*;
(
    input  logic     clock,
    input  logic     reset,

    // From memory
    input  mem_tag_t transaction_tag,
    input  mem_rsp_t mem_rsp,

    // From the arbiter
    input  port_id_t grant_port,
    input  logic     grant_valid,

    // Toward the caches and the arbiter
    output mem_tag_t port_tags [N_PORTS],
    output mem_rsp_t port_rsps [N_PORTS],
    output logic     credit_return
);

    // Owner table indexed by memory tag, entry 0 unused
    logic     owned [MEM_TAGS+1];
    port_id_t owner [MEM_TAGS+1];

    logic     new_tag;
    logic     data_in;
    logic     data_owned;

    assign new_tag    = grant_valid && (transaction_tag != '0);
    assign data_in    = (mem_rsp.tag != '0);
    assign data_owned = data_in && owned[mem_rsp.tag];

    // One credit back per data response
    assign credit_return = data_in;

    always_comb begin
        for (int p = 0; p < N_PORTS; p++) begin
            // Tag only to the granted cache
            port_tags[p] = (new_tag && (grant_port == port_id_t'(p))) ? transaction_tag : '0;
            // Data everywhere, tag only to the owner
            port_rsps[p].data = mem_rsp.data;
            port_rsps[p].tag  = (data_owned && (owner[mem_rsp.tag] == port_id_t'(p)))
                              ? mem_rsp.tag : '0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int t = 0; t <= MEM_TAGS; t++) begin
                owned[t] <= 1'b0;
            end
        end else begin
            if (data_in) begin
                owned[mem_rsp.tag] <= 1'b0;
            end
            // A tag reused in the same cycle keeps its new owner
            if (new_tag) begin
                owned[transaction_tag] <= 1'b1;
                owner[transaction_tag] <= grant_port;
            end
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build the fetch subsystem testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module fetch_tb -f verilog.f

# The search below decides pass or fail, a failing run also exits nonzero
output=$(./obj_dir/Vfetch_tb 2>&1) || true
echo "$output"

if grep -qx "PASS: all tests" <<< "$output"; then
    exit 0
else
    echo "Simulation did not pass"
    exit 1
fi

// File: tb/fetch_tb.sv
/*
 * Testbench for the fetch memory subsystem. Random per-thread address streams
 * from a small block pool, a tagged memory model and a per-port line model
 * that predicts hits and checks every returned instruction.
 */

`timescale 1ns/1ps

module fetch_tb
    import mem_pkg::*;
    import icache_pkg::*;
();

    ////////////////////////////////////////
    // Run length and limits
    ////////////////////////////////////////

    localparam int N_CYCLES = 3000;
    // Worst miss, credit starvation plus round robin plus memory latency
    localparam int MISS_BOUND = 80;
    localparam int TIMEOUT_CYCLES = N_CYCLES * MISS_BOUND + 100;

    logic        clock = 1'b0;
    logic        reset;
    fetch_addr_t fetch_addrs [N_PORTS];
    fetch_rsp_t  fetch_rsps  [N_PORTS];
    mem_req_t    mem_req;
    mem_tag_t    transaction_tag;
    mem_rsp_t    mem_rsp;
    mem_tag_t    rsp_tag;
    mem_addr_t   rsp_addr;
    logic        overrun;

    // Reference state per port, which block each line holds
    logic        model_valid [N_PORTS][ICACHE_LINES];
    cache_tag_t  model_tag   [N_PORTS][ICACHE_LINES];
    int          fills       [N_PORTS];
    int          wait_cycles [N_PORTS];
    logic        any_rsp;

    always #5 clock = ~clock;

    fetch_mem_subsystem dut0 (
        .clock           (clock),
        .reset           (reset),
        .fetch_addrs     (fetch_addrs),
        .fetch_rsps      (fetch_rsps),
        .mem_req         (mem_req),
        .transaction_tag (transaction_tag),
        .mem_rsp         (mem_rsp)
    );

    mem_model mem0 (
        .clock           (clock),
        .reset           (reset),
        .mem_req         (mem_req),
        .transaction_tag (transaction_tag),
        .rsp_tag         (rsp_tag),
        .rsp_addr        (rsp_addr),
        .overrun         (overrun)
    );

    ////////////////////////////////////////
    // Memory contents and stimulus
    ////////////////////////////////////////

    // Fixed block contents, both halves depend on the whole address
    function automatic logic [63:0] block_value(input mem_addr_t addr);
        logic [31:0] lo;
        logic [31:0] hi;
        lo = {addr ^ 16'h3c3c, addr};
        hi = {~addr, addr ^ 16'h0f5a} ^ 32'h5a5a_0000;
        return {hi, lo};
    endfunction

    always_comb begin
        mem_rsp.tag       = rsp_tag;
        mem_rsp.data.word = block_value(rsp_addr);
    end

    // 24 blocks over 8 lines, three tags fight for each line
    function automatic fetch_addr_t random_addr();
        fetch_addr_t a;
        a.tag         = cache_tag_t'($urandom % 3);
        a.index       = line_index_t'($urandom % 8);
        a.insn_sel    = 1'($urandom % 2);
        a.byte_offset = 2'b00;
        return a;
    endfunction

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            report_failure($sformatf("** Error: %s is 0x%0h, expected 0x%0h",
                                     name, got, expected));
        end
    endtask

    // No fetch valid and no load while reset is held
    task automatic check_reset_outputs();
        for (int p = 0; p < N_PORTS; p++) begin
            check_value($sformatf("fetch_rsps[%0d].valid", p), 64'(fetch_rsps[p].valid), 64'(0));
        end
        check_value("mem_req.command", 64'(mem_req.command), 64'(mem_none));
    endtask

    task automatic check_port(input int p);
        fetch_addr_t a;
        fetch_rsp_t  r;
        logic        held;
        logic [63:0] blk;
        logic [31:0] exp_insn;
        a = fetch_addrs[p];
        r = fetch_rsps[p];
        held = model_valid[p][a.index] && (model_tag[p][a.index] == a.tag);
        // Nothing can be valid before the first data return
        if (!any_rsp) begin
            check_value($sformatf("fetch_rsps[%0d].valid", p), 64'(r.valid), 64'(0));
        end
        // Known line gives a hit at once
        if (held) begin
            check_value($sformatf("fetch_rsps[%0d].valid", p), 64'(r.valid), 64'(1));
        end
        if (r.valid) begin
            blk      = block_value({a.tag, a.index, 3'b000});
            exp_insn = a.insn_sel ? blk[63:32] : blk[31:0];
            check_value($sformatf("fetch_rsps[%0d].insn", p), 64'(r.insn), 64'(exp_insn));
            if (!held) begin
                fills[p]++;
            end
            model_valid[p][a.index] = 1'b1;
            model_tag[p][a.index]   = a.tag;
            wait_cycles[p]          = 0;
        end else begin
            wait_cycles[p]++;
            if (wait_cycles[p] > MISS_BOUND) begin
                report_failure($sformatf("Port %0d held address 0x%0h for %0d cycles without a response",
                                         p, a, wait_cycles[p]));
            end
        end
    endtask

    // Hold or move, abandoning a miss now and then
    task automatic drive_port(input int p);
        logic move;
        if (fetch_rsps[p].valid) begin
            move = ($urandom % 2) == 0;
        end else begin
            move = ($urandom % 8) == 0;
        end
        if (move) begin
            fetch_addrs[p] = random_addr();
            wait_cycles[p] = 0;
        end
    endtask

    ////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////

    initial begin
        int starved;
        void'($urandom(32'h3313_4da3));
        reset   = 1'b1;
        any_rsp = 1'b0;
        for (int p = 0; p < N_PORTS; p++) begin
            fetch_addrs[p] = random_addr();
            fills[p]       = 0;
            wait_cycles[p] = 0;
            for (int i = 0; i < ICACHE_LINES; i++) begin
                model_valid[p][i] = 1'b0;
                model_tag[p][i]   = '0;
            end
        end
        repeat (2) begin
            @(negedge clock);
            check_reset_outputs();
        end
        reset = 1'b0;

        repeat (N_CYCLES) begin
            @(negedge clock);
            // Sample everything first, then drive
            for (int p = 0; p < N_PORTS; p++) begin
                check_port(p);
            end
            check_value("mem_model overrun", 64'(overrun), 64'(0));
            if (mem_rsp.tag != '0) begin
                any_rsp = 1'b1;
            end
            for (int p = 0; p < N_PORTS; p++) begin
                drive_port(p);
            end
        end

        // Round robin gives every thread its misses
        starved = 0;
        for (int p = 0; p < N_PORTS; p++) begin
            if (fills[p] == 0) begin
                starved++;
            end
        end
        if (starved != 0) begin
            report_failure($sformatf("%0d threads never completed a miss", starved));
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clock);
        report_failure($sformatf("Timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end

endmodule

// File: tb/mem_model.sv
/*
 * Tagged memory model for the fetch testbench. Hands out the lowest free tag
 * with each load, returns the block address 3 to 12 cycles later and flags
 * any load that arrives while all tags are live.
 */

`timescale 1ns/1ps

module mem_model
    import mem_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  mem_req_t  mem_req,
    output mem_tag_t  transaction_tag,
    output mem_tag_t  rsp_tag,
    output mem_addr_t rsp_addr,
    output logic      overrun
);

    // Live transactions, entry 0 unused
    logic      busy      [MEM_TAGS+1];
    mem_addr_t load_addr [MEM_TAGS+1];
    int        countdown [MEM_TAGS+1];

    // Lowest free tag, zero with no load or no free tag
    always_comb begin
        transaction_tag = '0;
        for (int t = MEM_TAGS; t >= 1; t--) begin
            if (!busy[t]) begin
                transaction_tag = mem_tag_t'(t);
            end
        end
        if (mem_req.command != mem_load) begin
            transaction_tag = '0;
        end
    end

    always @(posedge clock) begin : respond
        logic done;
        done = 1'b0;
        if (reset) begin
            for (int t = 0; t <= MEM_TAGS; t++) begin
                busy[t]      <= 1'b0;
                countdown[t] <= 0;
            end
            rsp_tag  <= '0;
            rsp_addr <= '0;
            overrun  <= 1'b0;
        end else begin
            rsp_tag <= '0;
            // At most one return per cycle, the others stay ready
            for (int t = 1; t <= MEM_TAGS; t++) begin
                if (busy[t] && (countdown[t] > 0)) begin
                    countdown[t] <= countdown[t] - 1;
                end else if (busy[t] && !done) begin
                    done      = 1'b1;
                    busy[t]  <= 1'b0;
                    rsp_tag  <= mem_tag_t'(t);
                    rsp_addr <= load_addr[t];
                end
            end
            if (mem_req.command == mem_load) begin
                if (transaction_tag == '0) begin
                    // Sticky, credit rule broken
                    overrun <= 1'b1;
                end else begin
                    busy[transaction_tag]      <= 1'b1;
                    load_addr[transaction_tag] <= mem_req.addr;
                    // Latency of 3 to 12 cycles
                    countdown[transaction_tag] <= 2 + int'($urandom % 10);
                end
            end
        end
    end

endmodule

// File: verilog.f
hw/mem_pkg.sv
hw/icache_pkg.sv
hw/icache.sv
hw/mem_request_arbiter.sv
hw/mem_response_router.sv
hw/fetch_mem_subsystem.sv
tb/mem_model.sv
tb/fetch_tb.sv
